// File: rtl/fetch_pkg.sv
// Burst fetch definitions
`default_nettype none

package fetch_pkg;

    localparam int ADDR_W = 24;
    localparam int DATA_W = 64;
    localparam int LEN_W  = 8;
    // Q, K and V readers
    localparam int N_CH   = 3;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [LEN_W-1:0]  len_t;
    typedef logic [1:0]        ch_idx_t;

    typedef enum logic [1:0] {
        CFG_BASE   = 2'd0,
        CFG_COUNT  = 2'd1,
        CFG_THRESH = 2'd2
    } cfg_field_t;

endpackage

`default_nettype wire

// File: rtl/lif_pkg.sv
// LIF neuron definitions
`default_nettype none

package lif_pkg;

    localparam int TIME_STEPS = 4;
    // One input current lane per time step
    localparam int CUR_W      = 16;
    // Wider than a lane so that the leak term cannot overflow
    localparam int MEM_W      = 18;

    typedef logic signed [CUR_W-1:0] current_t;
    typedef logic signed [MEM_W-1:0] membrane_t;
    typedef logic signed [MEM_W-1:0] thresh_t;

    // Bit t is the spike at step t
    typedef logic [TIME_STEPS-1:0] spikes_t;

endpackage

`default_nettype wire

// File: rtl/burst_rd_if.sv
// Burst read bus
`default_nettype none

interface burst_rd_if;
    import fetch_pkg::*;

    addr_t addr;
    len_t  len;
    logic  req;
    data_t data;
    logic  valid;
    logic  finish;

    // req, addr and len stay put until finish
    modport requester (
        output addr, len, req,
        input  data, valid, finish
    );

    modport server (
        input  addr, len, req,
        output data, valid, finish
    );

endinterface

`default_nettype wire

// File: rtl/burst_rd_arbiter.sv
// Round-robin burst read arbiter
`default_nettype none

module burst_rd_arbiter (
    input  logic                s_clk,
    input  logic                rst_n,
    burst_rd_if.server          req_bus [fetch_pkg::N_CH],
    output fetch_pkg::addr_t    rd_addr,
    output fetch_pkg::len_t     rd_len,
    output logic                rd_req,
    input  fetch_pkg::data_t    rd_data,
    input  logic                rd_valid,
    input  logic                rd_finish
);
    import fetch_pkg::*;

    logic [N_CH-1:0] req_vec;
    addr_t           addr_arr [N_CH];
    len_t            len_arr  [N_CH];
    logic            grant_vld;
    ch_idx_t         grant_idx;
    ch_idx_t         next_idx;
    logic            next_hit;

    for (genvar i = 0; i < N_CH; i++) begin : g_port
        assign req_vec[i]  = req_bus[i].req;
        assign addr_arr[i] = req_bus[i].addr;
        assign len_arr[i]  = req_bus[i].len;
        assign req_bus[i].data   = rd_data;
        assign req_bus[i].valid  = rd_valid && grant_vld && (grant_idx == ch_idx_t'(i));
        assign req_bus[i].finish = rd_finish && grant_vld && (grant_idx == ch_idx_t'(i));
    end

    // First requester after the last granted one
    always_comb begin
        int cand;
        next_hit = 1'b0;
        next_idx = grant_idx;
        for (int k = N_CH; k >= 1; k--) begin
            cand = (int'(grant_idx) + k) % N_CH;
            if (req_vec[cand]) begin
                next_hit = 1'b1;
                next_idx = ch_idx_t'(cand);
            end
        end
    end

    // grant_idx doubles as the round-robin pointer
    always_ff @(posedge s_clk or negedge rst_n) begin
        if (!rst_n) begin
            grant_vld <= 1'b0;
            grant_idx <= ch_idx_t'(N_CH - 1);
        end else if (grant_vld) begin
            if (rd_finish) begin
                grant_vld <= 1'b0;
            end
        end else if (next_hit) begin
            grant_vld <= 1'b1;
            grant_idx <= next_idx;
        end
    end

    assign rd_req  = grant_vld;
    assign rd_addr = addr_arr[grant_idx];
    assign rd_len  = len_arr[grant_idx];

endmodule

`default_nettype wire

// File: rtl/channel_cfg_regs.sv
// Per-channel configuration registers
`default_nettype none

module channel_cfg_regs (
    input  logic                   s_clk,
    input  logic                   rst_n,
    input  logic                   cfg_we,
    input  fetch_pkg::ch_idx_t     cfg_ch,
    input  fetch_pkg::cfg_field_t  cfg_field,
    input  logic [31:0]            cfg_wdata,
    output fetch_pkg::addr_t       base   [fetch_pkg::N_CH],
    output logic [15:0]            count  [fetch_pkg::N_CH],
    output lif_pkg::thresh_t       thresh [fetch_pkg::N_CH]
);
    import fetch_pkg::*;
    import lif_pkg::*;

    logic ch_ok;

    // Writes to the unused fourth index are dropped
    assign ch_ok = int'(cfg_ch) < N_CH;

    always_ff @(posedge s_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < N_CH; i++) begin
                base[i]   <= '0;
                count[i]  <= '0;
                thresh[i] <= '0;
            end
        end else if (cfg_we && ch_ok) begin
            case (cfg_field)
                CFG_BASE: begin
                    base[cfg_ch] <= cfg_wdata[ADDR_W-1:0];
                end
                CFG_COUNT: begin
                    count[cfg_ch] <= cfg_wdata[15:0];
                end
                CFG_THRESH: begin
                    thresh[cfg_ch] <= thresh_t'($signed(cfg_wdata[MEM_W-1:0]));
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/burst_rd_client.sv
// Burst read client
`default_nettype none

module burst_rd_client #(
    parameter int BURST_MAX = 16
) (
    input  logic               s_clk,
    input  logic               rst_n,
    input  logic               start,
    input  fetch_pkg::addr_t   base,
    input  logic [15:0]        count,
    burst_rd_if.requester      bus,
    output logic               busy,
    output logic               done
);
    import fetch_pkg::*;

    typedef enum logic {S_IDLE, S_FETCH} state_t;

    state_t      state;
    addr_t       base_q;
    logic [15:0] count_q;
    logic [15:0] fetched;
    logic [15:0] remaining;
    len_t        burst_len;
    logic        last_burst;

    assign remaining  = count_q - fetched;
    assign burst_len  = (remaining > 16'(BURST_MAX)) ? len_t'(BURST_MAX) : len_t'(remaining);
    assign last_burst = remaining == 16'(burst_len);

    // addr and len only move on finish
    assign bus.addr = base_q + addr_t'(fetched);
    assign bus.len  = burst_len;
    assign bus.req  = state == S_FETCH;
    assign busy     = state == S_FETCH;

    always_ff @(posedge s_clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            done    <= 1'b0;
            base_q  <= '0;
            count_q <= '0;
            fetched <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        base_q  <= base;
                        count_q <= count;
                        fetched <= '0;
                        if (count == '0) begin
                            done <= 1'b1;
                        end else begin
                            state <= S_FETCH;
                        end
                    end
                end
                default: begin
                    if (bus.finish) begin
                        fetched <= fetched + 16'(burst_len);
                        if (last_burst) begin
                            state <= S_IDLE;
                            done  <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/lif_timestep_unit.sv
// Leaky integrate-and-fire over four steps
`default_nettype none

module lif_timestep_unit (
    input  logic               s_clk,
    input  logic               rst_n,
    input  logic               word_valid,
    input  fetch_pkg::data_t   word,
    input  lif_pkg::thresh_t   thresh,
    output logic               spikes_valid,
    output lif_pkg::spikes_t   spikes
);
    import lif_pkg::*;

    spikes_t spk_next;

    // Membrane restarts at zero for every word
    always_comb begin
        membrane_t v;
        membrane_t h;
        current_t  cur;
        v        = '0;
        spk_next = '0;
        for (int t = 0; t < TIME_STEPS; t++) begin
            cur = current_t'(word[t*CUR_W +: CUR_W]);
            // Leak halfway toward the input current
            h = v + ((membrane_t'(cur) - v) >>> 1);
            if (h >= thresh) begin
                spk_next[t] = 1'b1;
                v           = '0;
            end else begin
                v = h;
            end
        end
    end

    always_ff @(posedge s_clk or negedge rst_n) begin
        if (!rst_n) begin
            spikes_valid <= 1'b0;
        end else begin
            spikes_valid <= word_valid;
        end
    end

    always_ff @(posedge s_clk) begin
        if (word_valid) begin
            spikes <= spk_next;
        end
    end

endmodule

`default_nettype wire

// File: rtl/attn_fetch_top.sv
// Attention input fetch top level
`default_nettype none

module attn_fetch_top #(
    parameter int BURST_MAX = 16
) (
    input  logic                          s_clk,
    input  logic                          rst_n,
    input  logic                          cfg_we,
    input  fetch_pkg::ch_idx_t            cfg_ch,
    input  fetch_pkg::cfg_field_t         cfg_field,
    input  logic [31:0]                   cfg_wdata,
    input  logic [fetch_pkg::N_CH-1:0]    start,
    output logic [fetch_pkg::N_CH-1:0]    busy,
    output logic [fetch_pkg::N_CH-1:0]    done,
    output logic [fetch_pkg::N_CH-1:0]    spikes_valid,
    output lif_pkg::spikes_t              spikes [fetch_pkg::N_CH],
    output fetch_pkg::addr_t              rd_addr,
    output fetch_pkg::len_t               rd_len,
    output logic                          rd_req,
    input  fetch_pkg::data_t              rd_data,
    input  logic                          rd_valid,
    input  logic                          rd_finish
);
    import fetch_pkg::*;
    import lif_pkg::*;

    addr_t       ch_base   [N_CH];
    logic [15:0] ch_count  [N_CH];
    thresh_t     ch_thresh [N_CH];

    burst_rd_if ch_bus [N_CH] ();

    channel_cfg_regs u_cfg (
        .s_clk     (s_clk),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_ch    (cfg_ch),
        .cfg_field (cfg_field),
        .cfg_wdata (cfg_wdata),
        .base      (ch_base),
        .count     (ch_count),
        .thresh    (ch_thresh)
    );

    // Channel 0 is Q, 1 is K, 2 is V
    for (genvar i = 0; i < N_CH; i++) begin : g_ch
        burst_rd_client #(
            .BURST_MAX (BURST_MAX)
        ) u_client (
            .s_clk (s_clk),
            .rst_n (rst_n),
            .start (start[i]),
            .base  (ch_base[i]),
            .count (ch_count[i]),
            .bus   (ch_bus[i]),
            .busy  (busy[i]),
            .done  (done[i])
        );

        lif_timestep_unit u_lif (
            .s_clk        (s_clk),
            .rst_n        (rst_n),
            .word_valid   (ch_bus[i].valid),
            .word         (ch_bus[i].data),
            .thresh       (ch_thresh[i]),
            .spikes_valid (spikes_valid[i]),
            .spikes       (spikes[i])
        );
    end

    burst_rd_arbiter u_arb (
        .s_clk     (s_clk),
        .rst_n     (rst_n),
        .req_bus   (ch_bus),
        .rd_addr   (rd_addr),
        .rd_len    (rd_len),
        .rd_req    (rd_req),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid),
        .rd_finish (rd_finish)
    );

endmodule

`default_nettype wire

// File: bench/ddr_read_model.sv
// Burst read memory model
`default_nettype none

module ddr_read_model (
    input  logic               s_clk,
    input  logic               rst_n,
    input  fetch_pkg::addr_t   rd_addr,
    input  fetch_pkg::len_t    rd_len,
    input  logic               rd_req,
    output fetch_pkg::data_t   rd_data,
    output logic               rd_valid,
    output logic               rd_finish
);
    timeunit 1ns;
    timeprecision 1ps;
    import fetch_pkg::*;

    integer seed = 76892;

    // Lane t of the word at address a
    function automatic data_t word_at(input addr_t a);
        data_t w;
        int    lane;
        for (int t = 0; t < 4; t++) begin
            lane = ((int'(a) * 37 + t * 11) % 256) - 64;
            w[t*16 +: 16] = 16'(lane);
        end
        return w;
    endfunction

    initial begin
        addr_t a;
        len_t  n;
        rd_data   = '0;
        rd_valid  = 1'b0;
        rd_finish = 1'b0;
        forever begin
            @(negedge s_clk);
            if (rst_n && rd_req) begin
                a = rd_addr;
                n = rd_len;
                for (int k = 0; k < int'(n); k++) begin
                    // One to four cycles before each word
                    repeat (1 + $unsigned($random(seed)) % 4) @(negedge s_clk);
                    rd_data  = word_at(a + addr_t'(k));
                    rd_valid = 1'b1;
                    @(negedge s_clk);
                    rd_valid = 1'b0;
                end
                rd_finish = 1'b1;
                @(negedge s_clk);
                rd_finish = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/attn_fetch_asserts.sv
// Attention fetch checkers
`default_nettype none

module attn_fetch_asserts #(
    parameter int BURST_MAX = 16
) (
    input logic                        s_clk,
    input logic                        rst_n,
    input logic                        cfg_we,
    input fetch_pkg::ch_idx_t          cfg_ch,
    input fetch_pkg::cfg_field_t       cfg_field,
    input logic [31:0]                 cfg_wdata,
    input logic [fetch_pkg::N_CH-1:0]  start,
    input logic [fetch_pkg::N_CH-1:0]  busy,
    input logic [fetch_pkg::N_CH-1:0]  done,
    input logic [fetch_pkg::N_CH-1:0]  spikes_valid,
    input lif_pkg::spikes_t            spikes [fetch_pkg::N_CH],
    input fetch_pkg::addr_t            rd_addr,
    input fetch_pkg::len_t             rd_len,
    input logic                        rd_req,
    input logic                        rd_finish
);
    timeunit 1ns;
    timeprecision 1ps;
    import fetch_pkg::*;
    import lif_pkg::*;

    logic            failed = 1'b0;
    logic            started;
    addr_t           base_sh  [N_CH];
    logic [15:0]     count_sh [N_CH];
    thresh_t         thr_sh   [N_CH];
    addr_t           exp_addr [N_CH];
    len_t            exp_len  [N_CH];
    logic [N_CH-1:0] busy_q;
    logic            req_q;
    ch_idx_t         last_ch;
    ch_idx_t         rr_ch;

    // Expected spikes for the word at address a
    function automatic logic [3:0] spikes_ref(input int a, input int th);
        logic [3:0] s;
        int         v;
        int         h;
        int         cur;
        s = '0;
        v = 0;
        for (int t = 0; t < 4; t++) begin
            cur = ((a * 37 + t * 11) % 256) - 64;
            h   = v + ((cur - v) >>> 1);
            if (h >= th) begin
                s[t] = 1'b1;
                v    = 0;
            end else begin
                v = h;
            end
        end
        return s;
    endfunction

    always_ff @(posedge s_clk or negedge rst_n) begin
        if (!rst_n) begin
            started <= 1'b0;
        end else if (|start) begin
            started <= 1'b1;
        end
    end

    // Configuration as seen on the write port
    always_ff @(posedge s_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < N_CH; i++) begin
                base_sh[i]  <= '0;
                count_sh[i] <= '0;
                thr_sh[i]   <= '0;
            end
        end else if (cfg_we && int'(cfg_ch) < N_CH) begin
            if (cfg_field == CFG_BASE) begin
                base_sh[cfg_ch] <= cfg_wdata[ADDR_W-1:0];
            end else if (cfg_field == CFG_COUNT) begin
                count_sh[cfg_ch] <= cfg_wdata[15:0];
            end else if (cfg_field == CFG_THRESH) begin
                thr_sh[cfg_ch] <= cfg_wdata[MEM_W-1:0];
            end
        end
    end

    for (genvar i = 0; i < N_CH; i++) begin : g_ch
        addr_t       next_a;
        logic [15:0] got;
        logic [15:0] cnt_q;
        logic [15:0] left;

        assign left        = cnt_q - got;
        assign exp_addr[i] = next_a;
        assign exp_len[i]  = len_t'((left < 16'(BURST_MAX)) ? left : 16'(BURST_MAX));

        always_ff @(posedge s_clk or negedge rst_n) begin
            if (!rst_n) begin
                next_a <= '0;
                got    <= '0;
                cnt_q  <= '0;
            end else if (start[i] && !busy[i]) begin
                next_a <= base_sh[i];
                got    <= '0;
                cnt_q  <= count_sh[i];
            end else if (spikes_valid[i]) begin
                next_a <= next_a + 1'b1;
                got    <= got + 1'b1;
            end
        end

        spikes_ok: assert property (@(posedge s_clk) disable iff (!rst_n)
            spikes_valid[i] |-> spikes[i] == spikes_ref(int'(next_a), int'(thr_sh[i])))
        else begin
            $error("ERROR %0t spikes[%0d] expected %b got %b", $time, i,
                spikes_ref(int'($sampled(next_a)), int'($sampled(thr_sh[i]))),
                $sampled(spikes[i]));
            failed = 1'b1;
        end

        done_ok: assert property (@(posedge s_clk) disable iff (!rst_n)
            done[i] |-> got == cnt_q)
        else begin
            $error("ERROR %0t done[%0d] spike count expected %0d got %0d", $time, i,
                $sampled(cnt_q), $sampled(got));
            failed = 1'b1;
        end
    end

    // Requests the arbiter saw one cycle before a grant shows on rd_req
    always_ff @(posedge s_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q  <= '0;
            req_q   <= 1'b0;
            last_ch <= ch_idx_t'(N_CH - 1);
        end else begin
            busy_q <= busy;
            req_q  <= rd_req;
            if (rd_req && !req_q) begin
                last_ch <= rr_ch;
            end
        end
    end

    // First waiting channel after the last granted one
    always_comb begin
        int   c;
        logic hit;
        rr_ch = ch_idx_t'(0);
        hit   = 1'b0;
        for (int k = 1; k <= N_CH; k++) begin
            c = (int'(last_ch) + k) % N_CH;
            if (!hit && busy_q[c]) begin
                rr_ch = ch_idx_t'(c);
                hit   = 1'b1;
            end
        end
    end

    // A new burst goes to the next channel in turn, at its next word
    grant_ok: assert property (@(posedge s_clk) disable iff (!rst_n)
        $rose(rd_req) |-> rd_addr == exp_addr[rr_ch] && rd_len == exp_len[rr_ch])
    else begin
        $error("ERROR %0t rd_addr/rd_len expected %0h/%0d got %0h/%0d", $time,
            $sampled(exp_addr[rr_ch]), $sampled(exp_len[rr_ch]),
            $sampled(rd_addr), $sampled(rd_len));
        failed = 1'b1;
    end

    len_ok: assert property (@(posedge s_clk) disable iff (!rst_n)
        rd_req |-> rd_len inside {[1:BURST_MAX]})
    else begin
        $error("ERROR %0t rd_len expected 1 to %0d got %0d", $time, BURST_MAX,
            $sampled(rd_len));
        failed = 1'b1;
    end

    release_ok: assert property (@(posedge s_clk) disable iff (!rst_n)
        rd_req && rd_finish |=> !rd_req)
    else begin
        $error("ERROR %0t rd_req expected 0 after finish got 1", $time);
        failed = 1'b1;
    end

    quiet_ok: assert property (@(posedge s_clk) disable iff (!rst_n)
        !started |-> !rd_req && !(|done) && !(|busy) && !(|spikes_valid))
    else begin
        $error("ERROR %0t before start rd_req %b done %b busy %b spikes_valid %b, expected 0",
            $time, $sampled(rd_req), $sampled(done), $sampled(busy), $sampled(spikes_valid));
        failed = 1'b1;
    end

endmodule

`default_nettype wire

// File: bench/attn_fetch_tb.sv
// Attention fetch testbench
`default_nettype none

module attn_fetch_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import fetch_pkg::*;
    import lif_pkg::*;

    localparam int BURST_MAX  = 16;
    // 90 words at up to five cycles each plus eight bursts, with wide margin
    localparam int MAX_CYCLES = 3000;

    logic             s_clk;
    logic             rst_n;
    logic             cfg_we;
    ch_idx_t          cfg_ch;
    cfg_field_t       cfg_field;
    logic [31:0]      cfg_wdata;
    logic [N_CH-1:0]  start;
    logic [N_CH-1:0]  busy;
    logic [N_CH-1:0]  done;
    logic [N_CH-1:0]  spikes_valid;
    spikes_t          spikes [N_CH];
    addr_t            rd_addr;
    len_t             rd_len;
    logic             rd_req;
    data_t            rd_data;
    logic             rd_valid;
    logic             rd_finish;
    int               cycles;

    always #5 s_clk = ~s_clk;

    attn_fetch_top #(
        .BURST_MAX (BURST_MAX)
    ) UUT (.*);

    ddr_read_model u_mem (.*);

    bind attn_fetch_top attn_fetch_asserts #(.BURST_MAX(BURST_MAX)) u_asserts (.*);

    always @(posedge s_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Simulation FAILED");
            $fatal(1, "Timeout, done did not arrive within %0d cycles", MAX_CYCLES);
        end
    end

    always @(negedge s_clk) begin
        if (UUT.u_asserts.failed) begin
            $display("Simulation FAILED");
            $fatal(1, "A bound assertion failed");
        end
    end

    task automatic cfg_write(input ch_idx_t ch, input cfg_field_t field, input int value);
        @(negedge s_clk);
        cfg_we    = 1'b1;
        cfg_ch    = ch;
        cfg_field = field;
        cfg_wdata = value;
        @(negedge s_clk);
        cfg_we = 1'b0;
    endtask

    // Pulse start and wait until every started channel reports done
    task automatic run_channels(input logic [N_CH-1:0] mask);
        logic [N_CH-1:0] seen;
        @(negedge s_clk);
        start = mask;
        @(negedge s_clk);
        start = '0;
        seen  = done;
        while ((seen & mask) != mask) begin
            @(negedge s_clk);
            seen = seen | done;
        end
    endtask

    initial begin
        s_clk     = 1'b0;
        rst_n     = 1'b0;
        cfg_we    = 1'b0;
        cfg_ch    = '0;
        cfg_field = CFG_BASE;
        cfg_wdata = '0;
        start     = '0;
        cycles    = 0;
        repeat (2) @(negedge s_clk);
        rst_n = 1'b1;

        cfg_write(2'd0, CFG_THRESH, 20);
        cfg_write(2'd1, CFG_THRESH, 40);
        cfg_write(2'd2, CFG_THRESH, 60);
        cfg_write(2'd0, CFG_BASE, 0);
        cfg_write(2'd0, CFG_COUNT, 5);
        cfg_write(2'd1, CFG_BASE, 100);
        cfg_write(2'd1, CFG_COUNT, 40);
        cfg_write(2'd2, CFG_COUNT, 0);

        run_channels(3'b111);
        run_channels(3'b011);
        repeat (2) @(negedge s_clk);

        if (UUT.u_asserts.failed) begin
            $display("Simulation FAILED");
            $fatal(1, "A bound assertion failed");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: build.f
rtl/fetch_pkg.sv
rtl/lif_pkg.sv
rtl/burst_rd_if.sv
rtl/burst_rd_arbiter.sv
rtl/channel_cfg_regs.sv
rtl/burst_rd_client.sv
rtl/lif_timestep_unit.sv
rtl/attn_fetch_top.sv
bench/ddr_read_model.sv
bench/attn_fetch_asserts.sv
bench/attn_fetch_tb.sv

// File: Bender.yml
package:
  name: attn_fetch

sources:
  - rtl/fetch_pkg.sv
  - rtl/lif_pkg.sv
  - rtl/burst_rd_if.sv
  - rtl/burst_rd_arbiter.sv
  - rtl/channel_cfg_regs.sv
  - rtl/burst_rd_client.sv
  - rtl/lif_timestep_unit.sv
  - rtl/attn_fetch_top.sv
  - target: test
    files:
      - bench/ddr_read_model.sv
      - bench/attn_fetch_asserts.sv
      - bench/attn_fetch_tb.sv
